// ==== include/ooo_defines.svh ====
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Datapath width
`define OOO_XLEN 32

// Reorder buffer size
`define OOO_ROB_DEPTH 8
// Tag indexes the ROB directly
`define OOO_ROB_TAG_W 3

// Reservation station slots
`define OOO_RS_DEPTH 4

// Architectural registers
`define OOO_NREGS 32

// Unit latencies in cycles
`define OOO_FAST_LAT 1
`define OOO_MUL_LAT 3

`endif

// ==== hdl/ooo_pkg.sv ====
`include "ooo_defines.svh"

package ooo_pkg;

    // Operation encoding on the issue port
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_ADDI = 4'd7,
        OP_MUL  = 4'd8
    } op_e;

    typedef logic [`OOO_XLEN-1:0] data_t;

    typedef logic [`OOO_ROB_TAG_W-1:0] rob_tag_t;

    typedef logic [$clog2(`OOO_NREGS)-1:0] reg_idx_t;

    // Operations that go to the multiply unit
    function automatic logic is_mul(op_e op);
        return op == OP_MUL;
    endfunction

endpackage

// ==== hdl/rename_regfile.sv ====
`include "ooo_defines.svh"

module rename_regfile (
    input  logic              clk,
    input  logic              rst,
    input  ooo_pkg::reg_idx_t rd_idx1,
    input  ooo_pkg::reg_idx_t rd_idx2,
    output ooo_pkg::data_t    rd_val1,
    output ooo_pkg::data_t    rd_val2,
    output logic              rd_busy1,
    output logic              rd_busy2,
    output ooo_pkg::rob_tag_t rd_tag1,
    output ooo_pkg::rob_tag_t rd_tag2,
    input  logic              alloc_en,
    input  ooo_pkg::reg_idx_t alloc_rd,
    input  ooo_pkg::rob_tag_t alloc_tag,
    input  logic              wb_en,
    input  ooo_pkg::reg_idx_t wb_rd,
    input  ooo_pkg::rob_tag_t wb_tag,
    input  ooo_pkg::data_t    wb_data
);

    ooo_pkg::data_t        regs [`OOO_NREGS];
    ooo_pkg::rob_tag_t     tags [`OOO_NREGS];
    logic [`OOO_NREGS-1:0] busy;
    logic                  alloc_hit;
    logic                  wb_hit;

    // Register 0 stays out of both update paths
    assign alloc_hit = alloc_en && (alloc_rd != '0);
    assign wb_hit    = wb_en && (wb_rd != '0);

    assign rd_val1  = regs[rd_idx1];
    assign rd_val2  = regs[rd_idx2];
    assign rd_busy1 = busy[rd_idx1];
    assign rd_busy2 = busy[rd_idx2];
    assign rd_tag1  = tags[rd_idx1];
    assign rd_tag2  = tags[rd_idx2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `OOO_NREGS; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
            busy <= '0;
        end else begin
            if (wb_hit) begin
                regs[wb_rd] <= wb_data;
                // Only the newest producer releases the register
                if (tags[wb_rd] == wb_tag) begin
                    busy[wb_rd] <= 1'b0;
                end
            end
            // Rename in the same cycle overrides the release
            if (alloc_hit) begin
                busy[alloc_rd] <= 1'b1;
                tags[alloc_rd] <= alloc_tag;
            end
        end
    end

endmodule

// ==== hdl/reservation_station.sv ====
`include "ooo_defines.svh"

module reservation_station (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_en,
    input  ooo_pkg::op_e      alloc_op,
    input  ooo_pkg::rob_tag_t alloc_tag,
    input  ooo_pkg::data_t    alloc_val1,
    input  ooo_pkg::data_t    alloc_val2,
    input  logic              alloc_pend1,
    input  logic              alloc_pend2,
    input  ooo_pkg::rob_tag_t alloc_src1,
    input  ooo_pkg::rob_tag_t alloc_src2,
    input  logic              cdb0_valid,
    input  ooo_pkg::rob_tag_t cdb0_tag,
    input  ooo_pkg::data_t    cdb0_data,
    input  logic              cdb1_valid,
    input  ooo_pkg::rob_tag_t cdb1_tag,
    input  ooo_pkg::data_t    cdb1_data,
    output logic              rs_full,
    output logic              fast_valid,
    output ooo_pkg::op_e      fast_op,
    output ooo_pkg::rob_tag_t fast_tag,
    output ooo_pkg::data_t    fast_a,
    output ooo_pkg::data_t    fast_b,
    output logic              mul_valid,
    output ooo_pkg::rob_tag_t mul_tag,
    output ooo_pkg::data_t    mul_a,
    output ooo_pkg::data_t    mul_b
);

    localparam int IDX_W = $clog2(`OOO_RS_DEPTH);

    logic [`OOO_RS_DEPTH-1:0] ent_valid;
    logic [`OOO_RS_DEPTH-1:0] ent_pend1;
    logic [`OOO_RS_DEPTH-1:0] ent_pend2;
    ooo_pkg::op_e             ent_op   [`OOO_RS_DEPTH];
    ooo_pkg::rob_tag_t        ent_tag  [`OOO_RS_DEPTH];
    ooo_pkg::rob_tag_t        ent_src1 [`OOO_RS_DEPTH];
    ooo_pkg::rob_tag_t        ent_src2 [`OOO_RS_DEPTH];
    ooo_pkg::data_t           ent_val1 [`OOO_RS_DEPTH];
    ooo_pkg::data_t           ent_val2 [`OOO_RS_DEPTH];

    logic [`OOO_RS_DEPTH-1:0] ready;
    logic [`OOO_RS_DEPTH-1:0] hit0_1, hit1_1, hit0_2, hit1_2;
    logic                     free_found, fast_found, mul_found;
    logic [IDX_W-1:0]         free_idx, fast_idx, mul_idx;

    // Walk down so the lowest index wins each pick
    always_comb begin
        free_found = 1'b0;
        fast_found = 1'b0;
        mul_found  = 1'b0;
        free_idx   = '0;
        fast_idx   = '0;
        mul_idx    = '0;
        for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
            ready[i]  = ent_valid[i] && !ent_pend1[i] && !ent_pend2[i];
            hit0_1[i] = ent_pend1[i] && cdb0_valid && (cdb0_tag == ent_src1[i]);
            hit1_1[i] = ent_pend1[i] && cdb1_valid && (cdb1_tag == ent_src1[i]);
            hit0_2[i] = ent_pend2[i] && cdb0_valid && (cdb0_tag == ent_src2[i]);
            hit1_2[i] = ent_pend2[i] && cdb1_valid && (cdb1_tag == ent_src2[i]);
            if (!ent_valid[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
            if (ready[i] && ooo_pkg::is_mul(ent_op[i])) begin
                mul_found = 1'b1;
                mul_idx   = IDX_W'(i);
            end else if (ready[i]) begin
                fast_found = 1'b1;
                fast_idx   = IDX_W'(i);
            end
        end
    end

    assign rs_full = !free_found;

    assign fast_valid = fast_found;
    assign fast_op    = ent_op[fast_idx];
    assign fast_tag   = ent_tag[fast_idx];
    assign fast_a     = ent_val1[fast_idx];
    assign fast_b     = ent_val2[fast_idx];

    assign mul_valid = mul_found;
    assign mul_tag   = ent_tag[mul_idx];
    assign mul_a     = ent_val1[mul_idx];
    assign mul_b     = ent_val2[mul_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid <= '0;
            ent_pend1 <= '0;
            ent_pend2 <= '0;
        end else begin
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                if (hit0_1[i] || hit1_1[i]) begin
                    ent_pend1[i] <= 1'b0;
                end
                if (hit0_2[i] || hit1_2[i]) begin
                    ent_pend2[i] <= 1'b0;
                end
            end
            // Dispatched entries leave the station
            if (fast_found) begin
                ent_valid[fast_idx] <= 1'b0;
            end
            if (mul_found) begin
                ent_valid[mul_idx] <= 1'b0;
            end
            if (alloc_en) begin
                ent_valid[free_idx] <= 1'b1;
                ent_pend1[free_idx] <= alloc_pend1;
                ent_pend2[free_idx] <= alloc_pend2;
            end
        end
    end

    // Operand capture from the buses, then the new entry
    always_ff @(posedge clk) begin
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (hit0_1[i]) begin
                ent_val1[i] <= cdb0_data;
            end else if (hit1_1[i]) begin
                ent_val1[i] <= cdb1_data;
            end
            if (hit0_2[i]) begin
                ent_val2[i] <= cdb0_data;
            end else if (hit1_2[i]) begin
                ent_val2[i] <= cdb1_data;
            end
        end
        if (alloc_en) begin
            ent_op[free_idx]   <= alloc_op;
            ent_tag[free_idx]  <= alloc_tag;
            ent_src1[free_idx] <= alloc_src1;
            ent_src2[free_idx] <= alloc_src2;
            ent_val1[free_idx] <= alloc_val1;
            ent_val2[free_idx] <= alloc_val2;
        end
    end

endmodule

// ==== hdl/alu_unit.sv ====
module alu_unit #(
    parameter int LATENCY = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  ooo_pkg::op_e      in_op,
    input  ooo_pkg::rob_tag_t in_tag,
    input  ooo_pkg::data_t    in_a,
    input  ooo_pkg::data_t    in_b,
    output logic              out_valid,
    output ooo_pkg::rob_tag_t out_tag,
    output ooo_pkg::data_t    out_data
);

    ooo_pkg::data_t     result;
    logic [LATENCY-1:0] valid_q;
    ooo_pkg::rob_tag_t  tag_q  [LATENCY];
    ooo_pkg::data_t     data_q [LATENCY];

    always_comb begin
        case (in_op)
            ooo_pkg::OP_ADD,
            ooo_pkg::OP_ADDI: result = in_a + in_b;
            ooo_pkg::OP_SUB:  result = in_a - in_b;
            ooo_pkg::OP_AND:  result = in_a & in_b;
            ooo_pkg::OP_OR:   result = in_a | in_b;
            ooo_pkg::OP_XOR:  result = in_a ^ in_b;
            // Shift amount is the low five bits
            ooo_pkg::OP_SLL:  result = in_a << in_b[4:0];
            ooo_pkg::OP_SRL:  result = in_a >> in_b[4:0];
            ooo_pkg::OP_MUL:  result = in_a * in_b;
            default:          result = '0;
        endcase
    end

    // Delay line with one stage per cycle of latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0]  <= in_tag;
        data_q[0] <= result;
        for (int i = 1; i < LATENCY; i++) begin
            tag_q[i]  <= tag_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = valid_q[LATENCY-1];
    assign out_tag   = tag_q[LATENCY-1];
    assign out_data  = data_q[LATENCY-1];

endmodule

// ==== hdl/reorder_buffer.sv ====
`include "ooo_defines.svh"

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_en,
    input  ooo_pkg::reg_idx_t alloc_rd,
    output ooo_pkg::rob_tag_t alloc_tag,
    output logic              rob_full,
    input  ooo_pkg::rob_tag_t q_tag1,
    input  ooo_pkg::rob_tag_t q_tag2,
    output logic              q_ready1,
    output logic              q_ready2,
    output ooo_pkg::data_t    q_data1,
    output ooo_pkg::data_t    q_data2,
    input  logic              cdb0_valid,
    input  ooo_pkg::rob_tag_t cdb0_tag,
    input  ooo_pkg::data_t    cdb0_data,
    input  logic              cdb1_valid,
    input  ooo_pkg::rob_tag_t cdb1_tag,
    input  ooo_pkg::data_t    cdb1_data,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::rob_tag_t commit_tag,
    output ooo_pkg::data_t    commit_data
);

    localparam int CNT_W = $clog2(`OOO_ROB_DEPTH + 1);

    ooo_pkg::reg_idx_t         entry_rd   [`OOO_ROB_DEPTH];
    ooo_pkg::data_t            entry_data [`OOO_ROB_DEPTH];
    logic [`OOO_ROB_DEPTH-1:0] entry_done;
    ooo_pkg::rob_tag_t         head;
    ooo_pkg::rob_tag_t         tail;
    logic [CNT_W-1:0]          count;
    logic                      retire;

    // New entries take the tail slot, so the slot number is the tag
    assign alloc_tag = tail;
    assign rob_full  = (count == CNT_W'(`OOO_ROB_DEPTH));

    // Head retires as soon as its result is in
    assign retire       = (count != '0) && entry_done[head];
    assign commit_valid = retire;
    assign commit_rd    = entry_rd[head];
    assign commit_tag   = head;
    assign commit_data  = entry_data[head];

    // Lookup for sources still renamed to an entry
    assign q_ready1 = entry_done[q_tag1];
    assign q_ready2 = entry_done[q_tag2];
    assign q_data1  = entry_data[q_tag1];
    assign q_data2  = entry_data[q_tag2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            entry_done <= '0;
        end else begin
            if (cdb0_valid) begin
                entry_done[cdb0_tag] <= 1'b1;
            end
            if (cdb1_valid) begin
                entry_done[cdb1_tag] <= 1'b1;
            end
            if (alloc_en) begin
                entry_done[tail] <= 1'b0;
                tail             <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(alloc_en) - CNT_W'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (cdb0_valid) begin
            entry_data[cdb0_tag] <= cdb0_data;
        end
        if (cdb1_valid) begin
            entry_data[cdb1_tag] <= cdb1_data;
        end
        if (alloc_en) begin
            entry_rd[tail] <= alloc_rd;
        end
    end

endmodule

// ==== hdl/ooo_core.sv ====
`include "ooo_defines.svh"

module ooo_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  ooo_pkg::op_e      issue_op,
    input  ooo_pkg::reg_idx_t issue_rd,
    input  ooo_pkg::reg_idx_t issue_rs1,
    input  ooo_pkg::reg_idx_t issue_rs2,
    input  logic [15:0]       issue_imm,
    output logic              full,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::data_t    commit_data
);

    logic              rf_busy  [2];
    ooo_pkg::rob_tag_t rf_tag   [2];
    ooo_pkg::data_t    rf_val   [2];
    logic              q_ready  [2];
    ooo_pkg::data_t    q_data   [2];
    logic              src_pend [2];
    ooo_pkg::data_t    src_val  [2];

    logic              accept, rob_full, rs_full, use_imm;
    ooo_pkg::data_t    imm_ext;
    ooo_pkg::rob_tag_t new_tag, commit_tag;

    logic              fast_valid, mul_valid, cdb0_valid, cdb1_valid;
    ooo_pkg::op_e      fast_op;
    ooo_pkg::rob_tag_t fast_tag, mul_tag, cdb0_tag, cdb1_tag;
    ooo_pkg::data_t    fast_a, fast_b, mul_a, mul_b, cdb0_data, cdb1_data;

    assign full    = rob_full || rs_full;
    assign accept  = issue_valid && !full;
    assign use_imm = (issue_op == ooo_pkg::OP_ADDI);
    assign imm_ext = {{(`OOO_XLEN - 16){issue_imm[15]}}, issue_imm};

    // Source from the register file, a finished ROB entry, or this cycle's bus
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_pend[s] = 1'b0;
            if (!rf_busy[s]) begin
                src_val[s] = rf_val[s];
            end else if (q_ready[s]) begin
                src_val[s] = q_data[s];
            end else if (cdb0_valid && (cdb0_tag == rf_tag[s])) begin
                src_val[s] = cdb0_data;
            end else if (cdb1_valid && (cdb1_tag == rf_tag[s])) begin
                src_val[s] = cdb1_data;
            end else begin
                src_pend[s] = 1'b1;
                src_val[s]  = '0;
            end
        end
    end

    rename_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .rd_idx1   (issue_rs1),
        .rd_idx2   (issue_rs2),
        .rd_val1   (rf_val[0]),
        .rd_val2   (rf_val[1]),
        .rd_busy1  (rf_busy[0]),
        .rd_busy2  (rf_busy[1]),
        .rd_tag1   (rf_tag[0]),
        .rd_tag2   (rf_tag[1]),
        .alloc_en  (accept),
        .alloc_rd  (issue_rd),
        .alloc_tag (new_tag),
        .wb_en     (commit_valid),
        .wb_rd     (commit_rd),
        .wb_tag    (commit_tag),
        .wb_data   (commit_data)
    );

    reorder_buffer u_rob (
        .clk          (clk),
        .rst          (rst),
        .alloc_en     (accept),
        .alloc_rd     (issue_rd),
        .alloc_tag    (new_tag),
        .rob_full     (rob_full),
        .q_tag1       (rf_tag[0]),
        .q_tag2       (rf_tag[1]),
        .q_ready1     (q_ready[0]),
        .q_ready2     (q_ready[1]),
        .q_data1      (q_data[0]),
        .q_data2      (q_data[1]),
        .cdb0_valid   (cdb0_valid),
        .cdb0_tag     (cdb0_tag),
        .cdb0_data    (cdb0_data),
        .cdb1_valid   (cdb1_valid),
        .cdb1_tag     (cdb1_tag),
        .cdb1_data    (cdb1_data),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_tag   (commit_tag),
        .commit_data  (commit_data)
    );

    // addi takes the immediate in place of the second source
    reservation_station u_rs (
        .clk         (clk),
        .rst         (rst),
        .alloc_en    (accept),
        .alloc_op    (issue_op),
        .alloc_tag   (new_tag),
        .alloc_val1  (src_val[0]),
        .alloc_val2  (use_imm ? imm_ext : src_val[1]),
        .alloc_pend1 (src_pend[0]),
        .alloc_pend2 (!use_imm && src_pend[1]),
        .alloc_src1  (rf_tag[0]),
        .alloc_src2  (rf_tag[1]),
        .cdb0_valid  (cdb0_valid),
        .cdb0_tag    (cdb0_tag),
        .cdb0_data   (cdb0_data),
        .cdb1_valid  (cdb1_valid),
        .cdb1_tag    (cdb1_tag),
        .cdb1_data   (cdb1_data),
        .rs_full     (rs_full),
        .fast_valid  (fast_valid),
        .fast_op     (fast_op),
        .fast_tag    (fast_tag),
        .fast_a      (fast_a),
        .fast_b      (fast_b),
        .mul_valid   (mul_valid),
        .mul_tag     (mul_tag),
        .mul_a       (mul_a),
        .mul_b       (mul_b)
    );

    // Fast unit drives bus 0
    alu_unit #(
        .LATENCY (`OOO_FAST_LAT)
    ) u_fast_alu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fast_valid),
        .in_op     (fast_op),
        .in_tag    (fast_tag),
        .in_a      (fast_a),
        .in_b      (fast_b),
        .out_valid (cdb0_valid),
        .out_tag   (cdb0_tag),
        .out_data  (cdb0_data)
    );

    // Multiply unit drives bus 1
    alu_unit #(
        .LATENCY (`OOO_MUL_LAT)
    ) u_mul_alu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mul_valid),
        .in_op     (ooo_pkg::OP_MUL),
        .in_tag    (mul_tag),
        .in_a      (mul_a),
        .in_b      (mul_b),
        .out_valid (cdb1_valid),
        .out_tag   (cdb1_tag),
        .out_data  (cdb1_data)
    );

endmodule

// ==== sim/tb_ooo_core.sv ====
`include "ooo_defines.svh"

module tb_ooo_core;
    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              rst;
    logic              issue_valid;
    ooo_pkg::op_e      issue_op;
    ooo_pkg::reg_idx_t issue_rd;
    ooo_pkg::reg_idx_t issue_rs1;
    ooo_pkg::reg_idx_t issue_rs2;
    logic [15:0]       issue_imm;
    logic              full;
    logic              commit_valid;
    ooo_pkg::reg_idx_t commit_rd;
    ooo_pkg::data_t    commit_data;

    // Architectural state as the program sees it
    ooo_pkg::data_t    model_regs [`OOO_NREGS];
    ooo_pkg::reg_idx_t exp_rd_q [$];
    ooo_pkg::data_t    exp_data_q [$];

    int     error_count  = 0;
    int     check_count  = 0;
    int     issued_count = 0;
    int     cycle_count  = 0;
    integer seed         = 32'hc7b41cbd;
    logic   full_seen    = 1'b0;

    ooo_core u_ooo_core (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_rd     (issue_rd),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_imm    (issue_imm),
        .full         (full),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Executes one instruction on the model in program order
    function automatic void apply_reference(ooo_pkg::op_e op, ooo_pkg::reg_idx_t rd,
                                            ooo_pkg::reg_idx_t rs1, ooo_pkg::reg_idx_t rs2,
                                            logic [15:0] imm);
        ooo_pkg::data_t a;
        ooo_pkg::data_t b;
        ooo_pkg::data_t r;
        a = model_regs[rs1];
        b = (op == ooo_pkg::OP_ADDI) ? {{16{imm[15]}}, imm} : model_regs[rs2];
        case (op)
            ooo_pkg::OP_ADD:  r = a + b;
            ooo_pkg::OP_SUB:  r = a - b;
            ooo_pkg::OP_AND:  r = a & b;
            ooo_pkg::OP_OR:   r = a | b;
            ooo_pkg::OP_XOR:  r = a ^ b;
            ooo_pkg::OP_SLL:  r = a << b[4:0];
            ooo_pkg::OP_SRL:  r = a >> b[4:0];
            ooo_pkg::OP_ADDI: r = a + b;
            ooo_pkg::OP_MUL:  r = a * b;
            default:          r = '0;
        endcase
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(r);
        // r0 is hardwired to zero
        if (rd != '0) begin
            model_regs[rd] = r;
        end
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    // Called 1 ns after a rising edge; returns 1 ns after the accepting edge
    task automatic issue_instr(input ooo_pkg::op_e op, input int rd, input int rs1,
                               input int rs2, input logic [15:0] imm);
        issue_valid = 1'b1;
        issue_op    = op;
        issue_rd    = ooo_pkg::reg_idx_t'(rd);
        issue_rs1   = ooo_pkg::reg_idx_t'(rs1);
        issue_rs2   = ooo_pkg::reg_idx_t'(rs2);
        issue_imm   = imm;
        @(negedge clk);
        while (full) begin
            full_seen = 1'b1;
            @(negedge clk);
        end
        apply_reference(op, issue_rd, issue_rs1, issue_rs2, imm);
        issued_count++;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_rd_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        $display("Test %0d %s: %0d errors", num, name, error_count - errors_before);
    endtask

    // Commits are compared mid-cycle against the model queue
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            if (exp_rd_q.size() == 0) begin
                error_count++;
                $display("Commit of r%0d arrived at %0t ns with nothing outstanding",
                         commit_rd, $time);
            end else begin
                check_equal(32'(commit_rd), 32'(exp_rd_q.pop_front()), "commit rd");
                check_equal(commit_data, exp_data_q.pop_front(), "commit data");
            end
        end
    end

    // Limit grows with every issued instruction
    initial begin
        while (cycle_count < 20 * issued_count + 200) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles: commits stopped arriving", cycle_count);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [15:0] imm;
        int          errs;
        for (int i = 0; i < `OOO_NREGS; i++) begin
            model_regs[i] = '0;
        end
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_op    = ooo_pkg::OP_ADD;
        issue_rd    = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_imm   = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle outputs, then every register reads back zero
        errs = error_count;
        check_equal(32'(commit_valid), 32'd0, "commit_valid after reset");
        check_equal(32'(full), 32'd0, "full after reset");
        for (int k = 0; k < `OOO_NREGS; k++) begin
            issue_instr(ooo_pkg::OP_ADDI, k, k, 0, 16'h0000);
        end
        wait_drain();
        report_test(1, "reset state", errs);

        errs = error_count;
        for (int round = 0; round < 3; round++) begin
            imm = 16'($random(seed));
            issue_instr(ooo_pkg::OP_ADDI, 1, 0, 0, imm);
            imm = 16'($random(seed));
            issue_instr(ooo_pkg::OP_ADDI, 2, 0, 0, imm);
            wait_drain();
            for (int k = 0; k < 9; k++) begin
                imm = 16'($random(seed));
                issue_instr(ooo_pkg::op_e'(k), 3 + k, 1, 2, imm);
            end
            wait_drain();
        end
        report_test(2, "all operations", errs);

        // Each step reads the previous destination
        errs = error_count;
        imm = 16'($random(seed));
        issue_instr(ooo_pkg::OP_ADDI, 5, 0, 0, imm);
        for (int k = 0; k < 9; k++) begin
            imm = 16'($random(seed));
            issue_instr(ooo_pkg::op_e'(k), 6 + k, 5 + k, 4 + k, imm);
        end
        wait_drain();
        report_test(3, "dependent chain", errs);

        errs = error_count;
        issue_instr(ooo_pkg::OP_MUL, 20, 1, 2, 16'h0000);
        for (int k = 0; k < 4; k++) begin
            issue_instr(ooo_pkg::OP_ADD, 21 + k, 3 + 2 * k, 4 + 2 * k, 16'h0000);
        end
        wait_drain();
        report_test(4, "mul then adds", errs);

        // Serial mul chain backs up the station
        errs = error_count;
        issue_instr(ooo_pkg::OP_ADDI, 10, 0, 0, 16'h0003);
        imm = 16'($random(seed));
        issue_instr(ooo_pkg::OP_ADDI, 11, 0, 0, imm);
        wait_drain();
        full_seen = 1'b0;
        for (int k = 0; k < 12; k++) begin
            if (k % 2 == 0) begin
                issue_instr(ooo_pkg::OP_MUL, 10, 10, 11, 16'h0000);
            end else begin
                issue_instr(ooo_pkg::OP_ADD, 12 + k / 2, 10, 1, 16'h0000);
            end
        end
        wait_drain();
        check_equal(32'(full_seen), 32'd1, "full seen during burst");
        report_test(5, "back-to-back burst", errs);

        errs = error_count;
        issue_instr(ooo_pkg::OP_ADDI, 0, 1, 0, 16'h007b);
        issue_instr(ooo_pkg::OP_MUL, 0, 1, 2, 16'h0000);
        issue_instr(ooo_pkg::OP_ADD, 25, 0, 0, 16'h0000);
        issue_instr(ooo_pkg::OP_OR, 26, 0, 1, 16'h0000);
        issue_instr(ooo_pkg::OP_SUB, 27, 1, 0, 16'h0000);
        wait_drain();
        report_test(6, "register zero", errs);

        $display("Tests: 6, checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/ooo_pkg.sv
hdl/rename_regfile.sv
hdl/reservation_station.sv
hdl/alu_unit.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
sim/tb_ooo_core.sv

// ==== Makefile ====
TOP = tb_ooo_core

.PHONY: sim clean

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
